// File: Makefile
SIM := obj_dir/Vtb_fifo_ctl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): compile.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module tb_fifo_ctl -f compile.f

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
fifo_ctl_pkg.sv
sync_fifo.sv
host_rx_router.sv
ctl_engine.sv
host_tx_mux.sv
fifo_ctl_top.sv
fifo_ctl_assertions.sv
tb_fifo_ctl.sv

// File: ctl_engine.sv
// Command engine; reads and masked 16-bit writes only, writes to rw need address bit 15 set and 14 clear
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module ctl_engine (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_cmd_valid,
    input  wire  [`HOST_W-1:0]        i_cmd_data,
    output logic                      o_cmd_ready,
    output logic                      o_resp_valid,
    output logic [`CTX_W+`TX_W-1:0]   o_resp_data,
    input  wire                       i_resp_ready,
    input  wire                       i_tx_valid,
    input  wire                       i_tx_ready
);

    localparam fifo_ctl_pkg::rw_file_t RW_RESET =
        {32'h0000_0000, 32'(`RW_BITS / 8), 16'h0000, `RW_MAGIC};

    logic [`HOST_W-1:0]          cmd_word;
    logic                        cmd_avail;
    logic                        cmd_pop;
    logic                        resp_af;       // Response queue nearly full
    logic                        resp_push;
    logic [`CTX_W+`TX_W-1:0]     resp_push_data;

    fifo_ctl_pkg::ro_file_t      ro;
    fifo_ctl_pkg::rw_file_t      rw;
    fifo_ctl_pkg::rw_file_t      wr_mask;
    fifo_ctl_pkg::rw_file_t      wr_val;
    fifo_ctl_pkg::cmd_op_t       cmd_op;
    logic [63:0]                 uptime;
    logic [63:0]                 idle_base;
    logic [15:0]                 cmd_addr;
    logic [17:0]                 cmd_bit;       // Byte address as bit offset
    logic [15:0]                 cmd_mask;
    logic [15:0]                 cmd_value;
    logic [`RO_BITS+15:0]        rd_shift;
    logic [15:0]                 rd_word;
    logic                        do_read;
    logic                        do_write;
    logic                        timer_fire;

    // --------------------
    // Queues
    // --------------------
    sync_fifo #(.WIDTH(`HOST_W), .DEPTH(`CMD_DEPTH)) u_cmd_q (
        .clk           (clk),
        .rst           (rst),
        .i_wr_valid    (i_cmd_valid),
        .i_wr_data     (i_cmd_data),
        .o_wr_ready    (o_cmd_ready),
        .o_rd_valid    (cmd_avail),
        .o_rd_data     (cmd_word),
        .i_rd_ready    (cmd_pop),
        .o_almost_full ()
    );

    // Pushes are gated by almost-full, so write ready is never low on a push
    sync_fifo #(.WIDTH(`CTX_W + `TX_W), .DEPTH(`RESP_DEPTH)) u_resp_q (
        .clk           (clk),
        .rst           (rst),
        .i_wr_valid    (resp_push),
        .i_wr_data     (resp_push_data),
        .o_wr_ready    (),
        .o_rd_valid    (o_resp_valid),
        .o_rd_data     (o_resp_data),
        .i_rd_ready    (i_resp_ready),
        .o_almost_full (resp_af)
    );

    // --------------------
    // Read-only file
    // --------------------
    assign ro[15:0]    = `RO_MAGIC;                 // +000
    assign ro[31:16]   = 16'h0000;                  // +002 reserved
    assign ro[63:32]   = 32'(`RO_BITS / 8);         // +004 byte count
    assign ro[71:64]   = `VERSION_MAJOR;            // +008
    assign ro[79:72]   = `VERSION_MINOR;            // +009
    assign ro[87:80]   = `DEVICE_ID;                // +00A
    assign ro[127:88]  = '0;                        // +00B slack
    assign ro[191:128] = uptime;                    // +010 clock ticks
    assign ro[255:192] = idle_base;                 // +018 last busy tick

    // --------------------
    // Command decode
    // --------------------
    assign cmd_addr  = cmd_word[31:16];
    assign cmd_bit   = {cmd_addr[14:0], 3'b000};
    assign cmd_mask  = {cmd_word[39:32], cmd_word[47:40]};     // Big-endian on the wire
    assign cmd_value = {cmd_word[55:48], cmd_word[63:56]};

    always_comb
    begin
        if (cmd_word[12])
            cmd_op = fifo_ctl_pkg::CMD_READ;        // Read wins over write
        else if (cmd_word[13])
            cmd_op = fifo_ctl_pkg::CMD_WRITE;
        else
            cmd_op = fifo_ctl_pkg::CMD_NONE;
    end

    // One pop per cycle, only with room for a response
    assign cmd_pop  = cmd_avail & ~resp_af;
    assign do_read  = cmd_pop & (cmd_op == fifo_ctl_pkg::CMD_READ);
    assign do_write = cmd_pop & (cmd_op == fifo_ctl_pkg::CMD_WRITE) & cmd_addr[15] & ~cmd_addr[14];

    // Zero padding makes reads past the end return 0
    always_comb
    begin
        if (cmd_addr[15])
            rd_shift = (`RO_BITS + 16)'(rw) >> cmd_bit;
        else
            rd_shift = (`RO_BITS + 16)'(ro) >> cmd_bit;
    end
    assign rd_word = rd_shift[15:0];

    // Write lanes outside the rw file shift away
    assign wr_mask = fifo_ctl_pkg::rw_file_t'(cmd_mask) << cmd_bit;
    assign wr_val  = fifo_ctl_pkg::rw_file_t'(cmd_value) << cmd_bit;

    // Idle past the trigger; reads and writes go first
    assign timer_fire = rw[`RW_TIMER_EN_BIT] & ~resp_af & ~do_read & ~do_write
                      & (idle_base + 64'(rw[`RW_BITS-1:`RW_TICKS_LSB]) < uptime);

    // --------------------
    // State
    // --------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            uptime    <= '0;
            idle_base <= '0;
        end
        else
        begin
            uptime <= uptime + 64'd1;
            if (i_tx_valid | ~i_tx_ready)
            begin
                idle_base <= uptime;                // Host link busy
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rw <= RW_RESET;                         // Timer enable off
        end
        else if (do_write)
        begin
            rw <= (rw & ~wr_mask) | (wr_val & wr_mask);
        end
        else if (timer_fire)
        begin
            rw[`RW_TIMER_EN_BIT] <= 1'b0;           // One-shot
        end
    end

    // Response stage, one cycle ahead of the queue
    always_ff @(posedge clk)
    begin
        if (rst)
            resp_push <= 1'b0;
        else
            resp_push <= do_read | timer_fire;
    end

    always_ff @(posedge clk)
    begin
        if (do_read)
            resp_push_data <= {2'b00, cmd_addr, rd_word[7:0], rd_word[15:8]};
        else if (timer_fire)
            resp_push_data <= {2'b00, `TIMER_EVT_ADDR, `TIMER_EVT_DATA};
    end

endmodule

`default_nettype wire

// File: fifo_ctl_assertions.sv
// Handshake rules on the fifo_ctl_top ports, sampled on rising clk; bound from this file
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module fifo_ctl_assertions (
    input wire                clk,
    input wire                rst,
    input wire                i_rx_valid,
    input wire                o_tlp_valid,
    input wire                o_tx_valid,
    input wire [`TX_W-1:0]    o_tx_data,
    input wire [`CTX_W-1:0]   o_tx_ctx,
    input wire                i_tx_ready
);

    // Stalled word holds
    property tx_hold;
        @(posedge clk) disable iff (rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data) && $stable(o_tx_ctx));
    endproperty

    tx_hold_a: assert property (tx_hold)
        else $error("Transmit word dropped or changed while stalled");

    // Synchronous reset empties the output register
    tx_reset_a: assert property (@(posedge clk) rst |=> !o_tx_valid)
        else $error("Transmit valid high after reset");

    tlp_valid_a: assert property (@(posedge clk) o_tlp_valid |-> i_rx_valid)   // Combinational path
        else $error("TLP out valid without host receive valid");

endmodule

bind fifo_ctl_top fifo_ctl_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .i_rx_valid  (i_rx_valid),
    .o_tlp_valid (o_tlp_valid),
    .o_tx_valid  (o_tx_valid),
    .o_tx_data   (o_tx_data),
    .o_tx_ctx    (o_tx_ctx),
    .i_tx_ready  (i_tx_ready)
);

`default_nettype wire

// File: fifo_ctl_defs.svh
// Host link constants and register map; host software must use the same magic values and offsets
`ifndef FIFO_CTL_DEFS_SVH
`define FIFO_CTL_DEFS_SVH

// --------------------
// Magic values
// --------------------
`define RX_MAGIC         8'h77      // Bits 7:0 of every host word
`define RO_MAGIC         16'hab89   // Read-only file, offset 0x000
`define RW_MAGIC         16'hefcd   // Read-write file, offset 0x000
`define TIMER_EVT_ADDR   16'hffff   // Inactivity event address field
`define TIMER_EVT_DATA   16'hcede   // Inactivity event data field

// Identification bytes
`define VERSION_MAJOR    8'h04
`define VERSION_MINOR    8'h02
`define DEVICE_ID        8'h03

// --------------------
// Widths and depths
// --------------------
`define HOST_W           64         // Inbound host word
`define TX_W             32         // Host transmit and TLP data
`define CTX_W            2          // Transmit context
`define LOOP_DEPTH       16
`define CMD_DEPTH        8
`define RESP_DEPTH       8

// --------------------
// Register files
// --------------------
`define RO_BITS          256        // 32 bytes
`define RW_BITS          96         // 12 bytes
`define RW_TIMER_EN_BIT  16         // Offset 0x002, bit 0
`define RW_TICKS_LSB     64         // Offset 0x008, 32-bit tick count

`endif

// File: fifo_ctl_pkg.sv
// Shared types for the host link; route codes follow bits 9:8 of the host word
`default_nettype none

`include "fifo_ctl_defs.svh"

package fifo_ctl_pkg;

    // Destination of an inbound word, from bits 9:8
    typedef enum logic [1:0] {
        ROUTE_TLP  = 2'b00,
        ROUTE_CFG  = 2'b01,     // Accepted and discarded
        ROUTE_LOOP = 2'b10,
        ROUTE_CMD  = 2'b11
    } route_t;

    // Command opcode, bit 12 read, bit 13 write
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_READ,
        CMD_WRITE
    } cmd_op_t;

    // Transmit mux lock state
    typedef enum logic {
        GRANT_IDLE,
        GRANT_TLP               // Mid-packet, TLP port only
    } grant_t;

    typedef logic [`RO_BITS-1:0] ro_file_t;
    typedef logic [`RW_BITS-1:0] rw_file_t;

endpackage

`default_nettype wire

// File: fifo_ctl_top.sv
// Host link router and control top; all streams valid/ready, PCIe CFG words are discarded
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module fifo_ctl_top (
    input  wire                  clk,
    input  wire                  rst,
    // Host receive
    input  wire                  i_rx_valid,
    input  wire  [`HOST_W-1:0]   i_rx_data,
    output logic                 o_rx_ready,
    // TLP out
    output logic                 o_tlp_valid,
    output logic [`TX_W-1:0]     o_tlp_data,
    output logic                 o_tlp_last,
    input  wire                  i_tlp_ready,
    // TLP in
    input  wire                  i_tlp_in_valid,
    input  wire  [`TX_W-1:0]     i_tlp_in_data,
    input  wire                  i_tlp_in_last,
    output logic                 o_tlp_in_ready,
    // Host transmit
    output logic                 o_tx_valid,
    output logic [`TX_W-1:0]     o_tx_data,
    output logic [`CTX_W-1:0]    o_tx_ctx,
    input  wire                  i_tx_ready
);

    logic                        loop_in_valid;
    logic [`CTX_W+`TX_W-1:0]     loop_in_data;
    logic                        loop_in_ready;
    logic                        loop_out_valid;
    logic [`CTX_W+`TX_W-1:0]     loop_out_data;
    logic                        loop_out_ready;
    logic                        cmd_valid;
    logic [`HOST_W-1:0]          cmd_data;
    logic                        cmd_ready;
    logic                        resp_valid;
    logic [`CTX_W+`TX_W-1:0]     resp_data;
    logic                        resp_ready;

    host_rx_router u_router (
        .i_rx_valid   (i_rx_valid),
        .i_rx_data    (i_rx_data),
        .o_rx_ready   (o_rx_ready),
        .o_tlp_valid  (o_tlp_valid),
        .o_tlp_data   (o_tlp_data),
        .o_tlp_last   (o_tlp_last),
        .i_tlp_ready  (i_tlp_ready),
        .o_loop_valid (loop_in_valid),
        .o_loop_data  (loop_in_data),
        .i_loop_ready (loop_in_ready),
        .o_cmd_valid  (cmd_valid),
        .o_cmd_data   (cmd_data),
        .i_cmd_ready  (cmd_ready)
    );

    // Loopback queue
    sync_fifo #(.WIDTH(`CTX_W + `TX_W), .DEPTH(`LOOP_DEPTH)) u_loop_q (
        .clk           (clk),
        .rst           (rst),
        .i_wr_valid    (loop_in_valid),
        .i_wr_data     (loop_in_data),
        .o_wr_ready    (loop_in_ready),
        .o_rd_valid    (loop_out_valid),
        .o_rd_data     (loop_out_data),
        .i_rd_ready    (loop_out_ready),
        .o_almost_full ()
    );

    // Transmit activity restarts the inactivity base
    ctl_engine u_ctl (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_valid  (cmd_valid),
        .i_cmd_data   (cmd_data),
        .o_cmd_ready  (cmd_ready),
        .o_resp_valid (resp_valid),
        .o_resp_data  (resp_data),
        .i_resp_ready (resp_ready),
        .i_tx_valid   (o_tx_valid),
        .i_tx_ready   (i_tx_ready)
    );

    host_tx_mux u_mux (
        .clk            (clk),
        .rst            (rst),
        .i_tlp_in_valid (i_tlp_in_valid),
        .i_tlp_in_data  (i_tlp_in_data),
        .i_tlp_in_last  (i_tlp_in_last),
        .o_tlp_in_ready (o_tlp_in_ready),
        .i_loop_valid   (loop_out_valid),
        .i_loop_data    (loop_out_data),
        .o_loop_ready   (loop_out_ready),
        .i_resp_valid   (resp_valid),
        .i_resp_data    (resp_data),
        .o_resp_ready   (resp_ready),
        .o_tx_valid     (o_tx_valid),
        .o_tx_data      (o_tx_data),
        .o_tx_ctx       (o_tx_ctx),
        .i_tx_ready     (i_tx_ready)
    );

endmodule

`default_nettype wire

// File: host_rx_router.sv
// Combinational steering of host words; bad-magic and CFG words are always accepted and dropped
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module host_rx_router (
    input  wire                       i_rx_valid,
    input  wire  [`HOST_W-1:0]        i_rx_data,
    output logic                      o_rx_ready,
    output logic                      o_tlp_valid,
    output logic [`TX_W-1:0]          o_tlp_data,
    output logic                      o_tlp_last,
    input  wire                       i_tlp_ready,
    output logic                      o_loop_valid,
    output logic [`CTX_W+`TX_W-1:0]   o_loop_data,
    input  wire                       i_loop_ready,
    output logic                      o_cmd_valid,
    output logic [`HOST_W-1:0]        o_cmd_data,
    input  wire                       i_cmd_ready
);

    logic                 magic_ok;
    fifo_ctl_pkg::route_t route;

    assign magic_ok = (i_rx_data[7:0] == `RX_MAGIC);
    assign route    = fifo_ctl_pkg::route_t'(i_rx_data[9:8]);

    // At most one destination sees valid
    assign o_tlp_valid  = i_rx_valid & magic_ok & (route == fifo_ctl_pkg::ROUTE_TLP);
    assign o_loop_valid = i_rx_valid & magic_ok & (route == fifo_ctl_pkg::ROUTE_LOOP);
    assign o_cmd_valid  = i_rx_valid & magic_ok & (route == fifo_ctl_pkg::ROUTE_CMD);

    // Payloads
    assign o_tlp_data  = i_rx_data[63:32];
    assign o_tlp_last  = i_rx_data[10];
    assign o_loop_data = {i_rx_data[11:10], i_rx_data[63:32]};    // Context on top
    assign o_cmd_data  = i_rx_data;

    // Ready of the selected destination
    always_comb
    begin
        if (!magic_ok)
        begin
            o_rx_ready = 1'b1;              // Drop
        end
        else
        begin
            case (route)
                fifo_ctl_pkg::ROUTE_TLP:  o_rx_ready = i_tlp_ready;
                fifo_ctl_pkg::ROUTE_LOOP: o_rx_ready = i_loop_ready;
                fifo_ctl_pkg::ROUTE_CMD:  o_rx_ready = i_cmd_ready;
                default:                  o_rx_ready = 1'b1;     // CFG dropped
            endcase
        end
    end

endmodule

`default_nettype wire

// File: host_tx_mux.sv
// Registered strict-priority merge; a TLP packet holds the output until its last word
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module host_tx_mux (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_tlp_in_valid,
    input  wire  [`TX_W-1:0]          i_tlp_in_data,
    input  wire                       i_tlp_in_last,
    output logic                      o_tlp_in_ready,
    input  wire                       i_loop_valid,
    input  wire  [`CTX_W+`TX_W-1:0]   i_loop_data,
    output logic                      o_loop_ready,
    input  wire                       i_resp_valid,
    input  wire  [`CTX_W+`TX_W-1:0]   i_resp_data,
    output logic                      o_resp_ready,
    output logic                      o_tx_valid,
    output logic [`TX_W-1:0]          o_tx_data,
    output logic [`CTX_W-1:0]         o_tx_ctx,
    input  wire                       i_tx_ready
);

    fifo_ctl_pkg::grant_t grant;
    logic                 out_free;     // Output register empty or draining
    logic                 idle;
    logic                 take_tlp;
    logic                 take_loop;
    logic                 take_resp;

    assign out_free = ~o_tx_valid | i_tx_ready;
    assign idle     = (grant == fifo_ctl_pkg::GRANT_IDLE);

    // Priority TLP, loopback, response
    assign o_tlp_in_ready = out_free;
    assign o_loop_ready   = out_free & idle & ~i_tlp_in_valid;
    assign o_resp_ready   = out_free & idle & ~i_tlp_in_valid & ~i_loop_valid;

    assign take_tlp  = i_tlp_in_valid & o_tlp_in_ready;
    assign take_loop = i_loop_valid & o_loop_ready;
    assign take_resp = i_resp_valid & o_resp_ready;

    // Control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_tx_valid <= 1'b0;
            grant      <= fifo_ctl_pkg::GRANT_IDLE;
        end
        else if (out_free)
        begin
            o_tx_valid <= take_tlp | take_loop | take_resp;
            if (take_tlp)
            begin
                grant <= i_tlp_in_last ? fifo_ctl_pkg::GRANT_IDLE : fifo_ctl_pkg::GRANT_TLP;
            end
        end
    end

    // Output word
    always_ff @(posedge clk)
    begin
        if (take_tlp)
        begin
            o_tx_data <= i_tlp_in_data;
            o_tx_ctx  <= {1'b0, i_tlp_in_last};
        end
        else if (take_loop)
        begin
            {o_tx_ctx, o_tx_data} <= i_loop_data;       // Loopback keeps its context
        end
        else if (take_resp)
        begin
            {o_tx_ctx, o_tx_data} <= i_resp_data;       // Context 0 from the engine
        end
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
// Single clock FIFO; DEPTH of 2 or more; read data is shown as soon as o_rd_valid is high
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_wr_valid,
    input  wire  [WIDTH-1:0] i_wr_data,
    output logic             o_wr_ready,
    output logic             o_rd_valid,
    output logic [WIDTH-1:0] o_rd_data,
    input  wire              i_rd_ready,
    output logic             o_almost_full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;       // Words stored
    logic             do_wr;
    logic             do_rd;

    assign o_wr_ready    = (count != CW'(DEPTH));
    assign o_rd_valid    = (count != '0);
    assign o_rd_data     = mem[rd_ptr];                 // Show-ahead read
    assign o_almost_full = (count >= CW'(DEPTH - 1));   // One slot or less left
    assign do_wr         = i_wr_valid & o_wr_ready;
    assign do_rd         = o_rd_valid & i_rd_ready;

    // Storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_wr) - CW'(do_rd);   // Both at once keeps count
        end
    end

endmodule

`default_nettype wire

// File: tb_fifo_ctl.sv
// Directed testbench for fifo_ctl_top; needs the defs header on the include path, every wait is bounded
`timescale 1ns/1ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module tb_fifo_ctl;

    localparam int TIMEOUT = 200;           // Cycles allowed per wait

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_rx_valid;
    logic [`HOST_W-1:0]    i_rx_data;
    logic                  o_rx_ready;
    logic                  o_tlp_valid;
    logic [`TX_W-1:0]      o_tlp_data;
    logic                  o_tlp_last;
    logic                  i_tlp_ready;
    logic                  i_tlp_in_valid;
    logic [`TX_W-1:0]      i_tlp_in_data;
    logic                  i_tlp_in_last;
    logic                  o_tlp_in_ready;
    logic                  o_tx_valid;
    logic [`TX_W-1:0]      o_tx_data;
    logic [`CTX_W-1:0]     o_tx_ctx;
    logic                  i_tx_ready;

    logic [33:0]           tx_q[$];         // {ctx, data} seen on host transmit
    logic [32:0]           tlp_q[$];        // {last, data} seen on TLP out
    int                    errors = 0;
    int                    checks = 0;

    fifo_ctl_top uut (
        .clk            (clk),
        .rst            (rst),
        .i_rx_valid     (i_rx_valid),
        .i_rx_data      (i_rx_data),
        .o_rx_ready     (o_rx_ready),
        .o_tlp_valid    (o_tlp_valid),
        .o_tlp_data     (o_tlp_data),
        .o_tlp_last     (o_tlp_last),
        .i_tlp_ready    (i_tlp_ready),
        .i_tlp_in_valid (i_tlp_in_valid),
        .i_tlp_in_data  (i_tlp_in_data),
        .i_tlp_in_last  (i_tlp_in_last),
        .o_tlp_in_ready (o_tlp_in_ready),
        .o_tx_valid     (o_tx_valid),
        .o_tx_data      (o_tx_data),
        .o_tx_ctx       (o_tx_ctx),
        .i_tx_ready     (i_tx_ready)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // --------------------
    // Output monitors
    // --------------------
    always @(posedge clk)
    begin
        if (!rst && o_tx_valid && i_tx_ready)
            tx_q.push_back({o_tx_ctx, o_tx_data});
        if (!rst && o_tlp_valid && i_tlp_ready)
            tlp_q.push_back({o_tlp_last, o_tlp_data});
    end

    // --------------------
    // Drive helpers
    // --------------------
    task automatic reset_dut();
        begin
            rst = 1'b1;
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
        end
    endtask

    // One host word, held until accepted
    task automatic send_rx(input logic [63:0] word);
        int   t;
        logic done;
        begin
            t    = 0;
            done = 1'b0;
            @(negedge clk);
            i_rx_valid = 1'b1;
            i_rx_data  = word;
            while (!done && t < TIMEOUT)
            begin
                @(posedge clk);
                done = o_rx_ready;          // Handshake at this edge
                t++;
            end
            checks++;
            assert (done) else
            begin
                errors++;
                $display("Host word %h was not accepted in time", word);
            end
            @(negedge clk);
            i_rx_valid = 1'b0;
        end
    endtask

    task automatic send_tlp_in(input logic [31:0] data, input logic last);
        int   t;
        logic done;
        begin
            t    = 0;
            done = 1'b0;
            @(negedge clk);
            i_tlp_in_valid = 1'b1;
            i_tlp_in_data  = data;
            i_tlp_in_last  = last;
            while (!done && t < TIMEOUT)
            begin
                @(posedge clk);
                done = o_tlp_in_ready;
                t++;
            end
            checks++;
            assert (done) else
            begin
                errors++;
                $display("Inbound TLP word %h was not accepted in time", data);
            end
            @(negedge clk);
            i_tlp_in_valid = 1'b0;
        end
    endtask

    // Command word with addr in 31:16, big-endian mask in 47:32 and value in 63:48
    function automatic logic [63:0] cmd_word(input logic rd, input logic wr,
                                             input logic [15:0] addr,
                                             input logic [15:0] mask,
                                             input logic [15:0] value);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                2'b00, wr, rd, 2'b00, 2'b11, `RX_MAGIC};
    endfunction

    // --------------------
    // Check helpers
    // --------------------
    task automatic wait_tx(input int n);
        int t;
        begin
            t = 0;
            while (tx_q.size() < n && t < TIMEOUT)
            begin
                @(negedge clk);             // Monitor pushes at posedge
                t++;
            end
            checks++;
            assert (tx_q.size() >= n) else
            begin
                errors++;
                $display("Only %0d of %0d transmit words arrived in time", tx_q.size(), n);
            end
        end
    endtask

    task automatic check_tx(input logic [1:0] exp_ctx, input logic [31:0] exp_data);
        logic [33:0] got;
        begin
            got = '0;
            wait_tx(1);
            if (tx_q.size() > 0)
            begin
                got = tx_q.pop_front();
                checks++;
                assert (got[33:32] == exp_ctx) else
                begin
                    errors++;
                    $display("Error: o_tx_ctx got %h expected %h", got[33:32], exp_ctx);
                end
                assert (got[31:0] == exp_data) else
                begin
                    errors++;
                    $display("Error: o_tx_data got %h expected %h", got[31:0], exp_data);
                end
            end
        end
    endtask

    // Nothing may come out for n cycles
    task automatic expect_silence(input int n);
        begin
            repeat (n) @(negedge clk);
            checks++;
            assert (tx_q.size() == 0 && tlp_q.size() == 0) else
            begin
                errors++;
                $display("Unexpected output of %0d transmit and %0d TLP words",
                         tx_q.size(), tlp_q.size());
                tx_q.delete();
                tlp_q.delete();
            end
        end
    endtask

    // Response carries the address and the 16-bit value with its bytes swapped
    task automatic read_and_compare(input logic [15:0] addr, input logic [15:0] value);
        begin
            send_rx(cmd_word(1'b1, 1'b0, addr, 16'h0000, 16'h0000));
            check_tx(2'b00, {addr, value[7:0], value[15:8]});
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] value);
        begin
            send_rx(cmd_word(1'b0, 1'b1, addr, mask, value));
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic loopback_order();
        logic [63:0] words[6];
        int          i;
        begin
            for (i = 0; i < 6; i++)
            begin
                words[i]      = {$urandom, $urandom};
                words[i][9:0] = {2'b10, `RX_MAGIC};     // Loopback type, random context
                send_rx(words[i]);
            end
            for (i = 0; i < 6; i++)
                check_tx(words[i][11:10], words[i][63:32]);
            expect_silence(10);
        end
    endtask

    task automatic routing_and_drops();
        logic [63:0] w;
        logic [32:0] got;
        int          i;
        begin
            for (i = 0; i < 4; i++)
            begin
                w      = {$urandom, $urandom};
                w[9:0] = {2'b00, `RX_MAGIC};
                send_rx(w);
                checks++;
                assert (tlp_q.size() == 1) else
                begin
                    errors++;
                    $display("TLP word %h did not appear on TLP out", w);
                end
                if (tlp_q.size() > 0)
                begin
                    got = tlp_q.pop_front();
                    assert (got[32] == w[10]) else
                    begin
                        errors++;
                        $display("Error: o_tlp_last got %h expected %h", got[32], w[10]);
                    end
                    assert (got[31:0] == w[63:32]) else
                    begin
                        errors++;
                        $display("Error: o_tlp_data got %h expected %h", got[31:0], w[63:32]);
                    end
                end
            end
            // Bad magic with any type, then CFG
            for (i = 0; i < 4; i++)
            begin
                w      = {$urandom, $urandom};
                w[9:8] = 2'(i);
                w[7:0] = 8'h5a;
                send_rx(w);
            end
            w      = {$urandom, $urandom};
            w[9:0] = {2'b01, `RX_MAGIC};
            send_rx(w);
            expect_silence(20);
        end
    endtask

    task automatic register_reads();
        begin
            read_and_compare(16'h0000, `RO_MAGIC);
            read_and_compare(16'h0008, {`VERSION_MINOR, `VERSION_MAJOR});  // Major at +008
            read_and_compare(16'h8000, `RW_MAGIC);
            read_and_compare(16'h0040, 16'h0000);      // Past the 32-byte ro file
            read_and_compare(16'h8010, 16'h0000);      // Past the 12-byte rw file
        end
    endtask

    task automatic masked_write();
        logic [15:0] mask;
        logic [15:0] value;
        begin
            mask  = 16'($urandom);
            value = 16'($urandom);
            write_reg(16'h8008, mask, value);
            read_and_compare(16'h8008, value & mask);  // Reset value 0 elsewhere
        end
    endtask

    task automatic priority_under_stall();
        logic [31:0] tlp_data[2];
        logic [63:0] loop_words[3];
        int          i;
        begin
            tlp_data[0] = $urandom;
            tlp_data[1] = $urandom;
            for (i = 0; i < 3; i++)
            begin
                loop_words[i]      = {$urandom, $urandom};
                loop_words[i][9:0] = {2'b10, `RX_MAGIC};
            end
            @(negedge clk);
            i_tx_ready = 1'b0;
            fork
                begin
                    @(negedge clk);             // First TLP meets a queued loopback word
                    send_tlp_in(tlp_data[0], 1'b0);
                    send_tlp_in(tlp_data[1], 1'b1);
                end
                begin
                    for (i = 0; i < 3; i++)
                        send_rx(loop_words[i]);
                    repeat (4) @(negedge clk);
                    i_tx_ready = 1'b1;          // Release the stall
                end
            join
            check_tx(2'b00, tlp_data[0]);
            check_tx(2'b01, tlp_data[1]);
            for (i = 0; i < 3; i++)
                check_tx(loop_words[i][11:10], loop_words[i][63:32]);
            expect_silence(20);                 // No duplicates
        end
    endtask

    task automatic inactivity_timer();
        begin
            write_reg(16'h8008, 16'hffff, 16'd20);     // Trigger ticks
            write_reg(16'h8002, 16'h0001, 16'h0001);   // Enable is bit 16 of the rw file
            check_tx(2'b00, {`TIMER_EVT_ADDR, `TIMER_EVT_DATA});
            expect_silence(60);                        // One shot only
            read_and_compare(16'h8002, 16'h0000);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        void'($urandom(32'h3b77));
        rst            = 1'b1;
        i_rx_valid     = 1'b0;
        i_rx_data      = '0;
        i_tlp_ready    = 1'b1;
        i_tlp_in_valid = 1'b0;
        i_tlp_in_data  = '0;
        i_tlp_in_last  = 1'b0;
        i_tx_ready     = 1'b1;
        reset_dut();
        loopback_order();
        routing_and_drops();
        register_reads();
        masked_write();
        priority_under_stall();
        inactivity_timer();
        $display("Checks run: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
